// ==== logic/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// ======================================================================
// Core geometry
// ======================================================================

`define RV_XLEN   32  // Data and instruction width
`define RV_NREGS  32  // Architectural registers, x0 included
`define RV_REG_AW 5   // Register index width

`endif

// ==== logic/rv_decode_pkg.sv ====
`include "rv_defines.svh"

package rv_decode_pkg;

  // ======================================================================
  // Basic words
  // ======================================================================

  typedef logic [`RV_XLEN-1:0]   data_t;
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // ======================================================================
  // Major opcodes, RV32I base set without SYSTEM and MISC-MEM
  // ======================================================================

  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111
  } opcode_t;

  // ======================================================================
  // ALU operations seen by the execute stage
  // ======================================================================

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10  // Operand B straight through, used by LUI
  } alu_op_t;

  // ======================================================================
  // Immediate layouts
  // ======================================================================

  typedef enum logic [2:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J,
    IMM_NONE  // R-type and unknown encodings
  } imm_fmt_t;

endpackage

// ==== logic/decode_ifs.sv ====
`timescale 1ns/100ps

// Decoder results toward the stage register
interface dec_if;
  import rv_decode_pkg::*;

  opcode_t   opcode;
  alu_op_t   alu_op;
  data_t     imm;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  logic      reg_write;
  logic      mem_write;
  logic      branch;
  logic      alu_src_imm;
  logic      illegal;

  modport producer (
    output opcode, alu_op, imm, rd, rs1, rs2,
    output reg_write, mem_write, branch, alu_src_imm, illegal
  );

  modport consumer (
    input opcode, alu_op, imm, rd, rs1, rs2,
    input reg_write, mem_write, branch, alu_src_imm, illegal
  );
endinterface

// Register file read ports
interface rf_read_if;
  import rv_decode_pkg::*;

  reg_addr_t rs1;
  reg_addr_t rs2;
  data_t     rs1_val;
  data_t     rs2_val;

  modport requester (output rs1, rs2);
  modport responder (input rs1, rs2, output rs1_val, rs2_val);
  modport observer  (input rs1_val, rs2_val);
endinterface

// ==== logic/instr_decoder.sv ====
`timescale 1ns/100ps
`include "rv_defines.svh"

module instr_decoder (
  input  rv_decode_pkg::data_t instr,
  dec_if.producer              dec,
  rf_read_if.requester         rf
);
  import rv_decode_pkg::*;

  logic [6:0] opc_bits;
  logic [2:0] funct3;
  logic       funct7_b5;
  logic       legal;
  opcode_t    opcode;
  imm_fmt_t   imm_fmt;
  data_t      imm;
  alu_op_t    alu_op;
  logic       reg_write;

  // Shared funct3 map for OP and OP_IMM
  function automatic alu_op_t funct_alu_op(input logic [2:0] f3,
                                           input logic       alt,
                                           input logic       is_reg);
    alu_op_t op;
    case (f3)
      3'b000:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;  // No SUBI
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opc_bits  = instr[6:0];
  assign funct3    = instr[14:12];
  assign funct7_b5 = instr[30];

  // ======================================================================
  // Opcode recognition
  // ======================================================================

  always_comb begin
    case (opc_bits)
      OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JAL, OPC_JALR,
      OPC_OP_IMM, OPC_OP, OPC_LUI, OPC_AUIPC: legal = 1'b1;
      default:                                legal = 1'b0;  // SYSTEM, FENCE and the rest
    endcase
  end

  assign opcode = legal ? opcode_t'(opc_bits) : OPC_OP_IMM;  // Unknown maps onto a NOP shape

  // ======================================================================
  // Immediate generation
  // ======================================================================

  always_comb begin
    case (opcode)
      OPC_LOAD, OPC_OP_IMM, OPC_JALR: imm_fmt = IMM_I;
      OPC_STORE:                      imm_fmt = IMM_S;
      OPC_BRANCH:                     imm_fmt = IMM_B;
      OPC_LUI, OPC_AUIPC:             imm_fmt = IMM_U;
      OPC_JAL:                        imm_fmt = IMM_J;
      default:                        imm_fmt = IMM_NONE;
    endcase
    if (!legal) begin
      imm_fmt = IMM_NONE;
    end
  end

  always_comb begin
    case (imm_fmt)
      IMM_I:   imm = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
      IMM_S:   imm = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
      IMM_B:   imm = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7],
                      instr[30:25], instr[11:8], 1'b0};
      IMM_U:   imm = {instr[31:12], 12'b0};
      IMM_J:   imm = {{(`RV_XLEN-21){instr[31]}}, instr[31], instr[19:12],
                      instr[20], instr[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  // ======================================================================
  // ALU operation and control flags
  // ======================================================================

  always_comb begin
    case (opcode)
      OPC_OP:     alu_op = funct_alu_op(funct3, funct7_b5, 1'b1);
      OPC_OP_IMM: alu_op = funct_alu_op(funct3, funct7_b5, 1'b0);
      OPC_LUI:    alu_op = ALU_PASS_B;
      OPC_BRANCH: alu_op = ALU_SUB;  // Compare by subtraction
      default:    alu_op = ALU_ADD;  // Address and link arithmetic
    endcase
    if (!legal) begin
      alu_op = ALU_ADD;
    end
  end

  assign reg_write = legal && (opcode != OPC_STORE) && (opcode != OPC_BRANCH);

  assign dec.opcode      = opcode;
  assign dec.alu_op      = alu_op;
  assign dec.imm         = imm;
  assign dec.rd          = reg_write ? instr[7 +: `RV_REG_AW] : '0;
  assign dec.rs1         = instr[15 +: `RV_REG_AW];
  assign dec.rs2         = instr[20 +: `RV_REG_AW];
  assign dec.reg_write   = reg_write;
  assign dec.mem_write   = legal && (opcode == OPC_STORE);
  assign dec.branch      = legal && (opcode == OPC_BRANCH);
  assign dec.alu_src_imm = legal && (opcode != OPC_OP) && (opcode != OPC_BRANCH);
  assign dec.illegal     = !legal;

  // Register file addresses go out raw, reads are harmless for any format
  assign rf.rs1 = instr[15 +: `RV_REG_AW];
  assign rf.rs2 = instr[20 +: `RV_REG_AW];

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/100ps
`include "rv_defines.svh"

module reg_file (
  input  logic                     clk,
  input  logic                     reset,
  rf_read_if.responder             rf,
  input  logic                     wb_en,
  input  rv_decode_pkg::reg_addr_t wb_rd,
  input  rv_decode_pkg::data_t     wb_data
);
  import rv_decode_pkg::*;

  data_t regs [1:`RV_NREGS-1];  // x0 has no storage

  // ======================================================================
  // Write port
  // ======================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && (wb_rd != '0)) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // ======================================================================
  // Read ports
  // ======================================================================

  // Zero register first, then bypass of the write in flight
  function automatic data_t read_port(input reg_addr_t addr);
    data_t val;
    if (addr == '0) begin
      val = '0;
    end else if (wb_en && (addr == wb_rd)) begin
      val = wb_data;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  always_comb begin
    rf.rs1_val = read_port(rf.rs1);
    rf.rs2_val = read_port(rf.rs2);
  end

endmodule

// ==== logic/id_ex_stage.sv ====
`timescale 1ns/100ps

module id_ex_stage (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     instr_valid,
  input  logic                     stall,
  dec_if.consumer                  dec,
  rf_read_if.observer              rf,
  output logic                     ex_valid,
  output logic                     ex_reg_write,
  output logic                     ex_mem_write,
  output logic                     ex_branch,
  output logic                     ex_alu_src_imm,
  output logic                     ex_illegal,
  output rv_decode_pkg::opcode_t   ex_opcode,
  output rv_decode_pkg::alu_op_t   ex_alu_op,
  output rv_decode_pkg::reg_addr_t ex_rd,
  output rv_decode_pkg::data_t     ex_rs1_val,
  output rv_decode_pkg::data_t     ex_rs2_val,
  output rv_decode_pkg::data_t     ex_imm
);
  import rv_decode_pkg::*;

  // ======================================================================
  // Control half
  // ======================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid       <= 1'b0;
      ex_reg_write   <= 1'b0;
      ex_mem_write   <= 1'b0;
      ex_branch      <= 1'b0;
      ex_alu_src_imm <= 1'b0;
      ex_illegal     <= 1'b0;
    end else if (!stall) begin
      ex_valid       <= instr_valid;
      ex_reg_write   <= instr_valid & dec.reg_write;  // Bubble writes nothing
      ex_mem_write   <= instr_valid & dec.mem_write;
      ex_branch      <= instr_valid & dec.branch;
      ex_alu_src_imm <= instr_valid & dec.alu_src_imm;
      ex_illegal     <= instr_valid & dec.illegal;
    end
  end

  // ======================================================================
  // Payload half
  // ======================================================================

  // Cleared on reset too so the execute stage sees an all-zero record
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_opcode  <= opcode_t'(7'd0);
      ex_alu_op  <= ALU_ADD;
      ex_rd      <= '0;
      ex_rs1_val <= '0;
      ex_rs2_val <= '0;
      ex_imm     <= '0;
    end else if (!stall) begin
      ex_opcode  <= dec.opcode;
      ex_alu_op  <= dec.alu_op;
      ex_rd      <= dec.rd;
      ex_rs1_val <= rf.rs1_val;  // Already bypassed in the register file
      ex_rs2_val <= rf.rs2_val;
      ex_imm     <= dec.imm;
    end
  end

endmodule

// ==== logic/decode_unit.sv ====
`timescale 1ns/100ps

module decode_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     instr_valid,
  input  logic                     stall,
  input  rv_decode_pkg::data_t     instr,
  input  logic                     wb_en,
  input  rv_decode_pkg::reg_addr_t wb_rd,
  input  rv_decode_pkg::data_t     wb_data,
  output logic                     ex_valid,
  output logic                     ex_reg_write,
  output logic                     ex_mem_write,
  output logic                     ex_branch,
  output logic                     ex_alu_src_imm,
  output logic                     ex_illegal,
  output rv_decode_pkg::opcode_t   ex_opcode,
  output rv_decode_pkg::alu_op_t   ex_alu_op,
  output rv_decode_pkg::reg_addr_t ex_rd,
  output rv_decode_pkg::data_t     ex_rs1_val,
  output rv_decode_pkg::data_t     ex_rs2_val,
  output rv_decode_pkg::data_t     ex_imm
);

  // ======================================================================
  // Internal buses
  // ======================================================================

  dec_if     dec_bus ();
  rf_read_if rf_bus ();

  // ======================================================================
  // Decode, operand read and stage register
  // ======================================================================

  instr_decoder u_decoder (
    .instr (instr),
    .dec   (dec_bus.producer),
    .rf    (rf_bus.requester)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .reset   (reset),
    .rf      (rf_bus.responder),
    .wb_en   (wb_en),
    .wb_rd   (wb_rd),
    .wb_data (wb_data)
  );

  id_ex_stage u_id_ex (
    .clk            (clk),
    .reset          (reset),
    .instr_valid    (instr_valid),
    .stall          (stall),
    .dec            (dec_bus.consumer),
    .rf             (rf_bus.observer),
    .ex_valid       (ex_valid),
    .ex_reg_write   (ex_reg_write),
    .ex_mem_write   (ex_mem_write),
    .ex_branch      (ex_branch),
    .ex_alu_src_imm (ex_alu_src_imm),
    .ex_illegal     (ex_illegal),
    .ex_opcode      (ex_opcode),
    .ex_alu_op      (ex_alu_op),
    .ex_rd          (ex_rd),
    .ex_rs1_val     (ex_rs1_val),
    .ex_rs2_val     (ex_rs2_val),
    .ex_imm         (ex_imm)
  );

endmodule

// ==== tb/decode_unit_chk.sv ====
`timescale 1ns/100ps
`include "rv_defines.svh"

module decode_unit_chk (
  input logic                     clk,
  input logic                     reset,
  input logic                     instr_valid,
  input logic                     stall,
  input rv_decode_pkg::data_t     instr,
  input logic                     wb_en,
  input rv_decode_pkg::reg_addr_t wb_rd,
  input rv_decode_pkg::data_t     wb_data,
  input logic                     ex_valid,
  input logic                     ex_reg_write,
  input logic                     ex_mem_write,
  input logic                     ex_branch,
  input logic                     ex_alu_src_imm,
  input logic                     ex_illegal,
  input rv_decode_pkg::opcode_t   ex_opcode,
  input rv_decode_pkg::alu_op_t   ex_alu_op,
  input rv_decode_pkg::reg_addr_t ex_rd,
  input rv_decode_pkg::data_t     ex_rs1_val,
  input rv_decode_pkg::data_t     ex_rs2_val,
  input rv_decode_pkg::data_t     ex_imm
);
  import rv_decode_pkg::*;

  int    fail_count = 0;
  data_t shadow [0:`RV_NREGS-1];
  logic  m_valid;
  data_t m_instr;
  data_t m_rs1;
  data_t m_rs2;

  // ======================================================================
  // Reference rules
  // ======================================================================

  function automatic logic is_legal(input data_t i);
    case (i[6:0])
      7'h03, 7'h23, 7'h63, 7'h6f, 7'h67, 7'h13, 7'h33, 7'h37, 7'h17: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic data_t exp_imm(input data_t i);
    case (i[6:0])
      7'h03, 7'h13, 7'h67: return {{20{i[31]}}, i[31:20]};
      7'h23:               return {{20{i[31]}}, i[31:25], i[11:7]};
      7'h63:               return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
      7'h37, 7'h17:        return {i[31:12], 12'h000};
      7'h6f:               return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
      default:             return '0;
    endcase
  endfunction

  function automatic alu_op_t exp_alu(input data_t i);
    logic [2:0] f3;
    f3 = i[14:12];
    if (i[6:0] == 7'h37) return ALU_PASS_B;
    if (i[6:0] == 7'h63) return ALU_SUB;
    if (i[6:0] != 7'h33 && i[6:0] != 7'h13) return ALU_ADD;
    case (f3)
      3'd0: return (i[30] && i[6:0] == 7'h33) ? ALU_SUB : ALU_ADD;
      3'd1: return ALU_SLL;
      3'd2: return ALU_SLT;
      3'd3: return ALU_SLTU;
      3'd4: return ALU_XOR;
      3'd5: return i[30] ? ALU_SRA : ALU_SRL;
      3'd6: return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Every legal opcode except STORE and BRANCH writes rd
  function automatic logic writes_rd(input data_t i);
    return i[6:0] inside {7'h03, 7'h13, 7'h17, 7'h33, 7'h37, 7'h67, 7'h6f};
  endfunction

  // Second ALU operand taken from the immediate
  function automatic logic imm_operand(input data_t i);
    return i[6:0] inside {7'h03, 7'h13, 7'h17, 7'h23, 7'h37, 7'h67, 7'h6f};
  endfunction

  // Flags in ex_ port order and all low for a bubble
  function automatic logic [4:0] exp_flags(input logic v, input data_t i);
    if (!v) return 5'b0;
    return {writes_rd(i), i[6:0] == 7'h23, i[6:0] == 7'h63, imm_operand(i), !is_legal(i)};
  endfunction

  function automatic data_t shadow_read(input reg_addr_t a);
    if (a == '0) return '0;
    if (wb_en && wb_rd == a) return wb_data;  // Bypass
    return shadow[a];
  endfunction

  // ======================================================================
  // Shadow model
  // ======================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RV_NREGS; i++) shadow[i] <= '0;
      m_valid <= 1'b0;
      m_instr <= '0;
      m_rs1   <= '0;
      m_rs2   <= '0;
    end else begin
      if (wb_en && wb_rd != '0) shadow[wb_rd] <= wb_data;
      if (!stall) begin
        m_valid <= instr_valid;
        m_instr <= instr;
        m_rs1   <= shadow_read(instr[19:15]);
        m_rs2   <= shadow_read(instr[24:20]);
      end
    end
  end

  // ======================================================================
  // Assertions
  // ======================================================================

  a_reset: assert property (@(posedge clk) reset |=> !ex_valid && !ex_reg_write && !ex_mem_write)
    else begin
      $error("Outputs not cleared after reset");
      fail_count++;
    end

  a_valid: assert property (@(posedge clk) disable iff (reset) ex_valid == m_valid)
    else begin
      $error("[ERROR] ex_valid exp %h got %h", $sampled(m_valid), $sampled(ex_valid));
      fail_count++;
    end

  a_hold: assert property (@(posedge clk) disable iff (reset) stall |=>
      $stable({ex_valid, ex_reg_write, ex_mem_write, ex_branch, ex_alu_src_imm, ex_illegal}) &&
      $stable(ex_opcode) && $stable(ex_alu_op) && $stable(ex_rd) &&
      $stable(ex_rs1_val) && $stable(ex_rs2_val) && $stable(ex_imm))
    else begin
      $error("Stage outputs changed under stall");
      fail_count++;
    end

  a_imm: assert property (@(posedge clk) disable iff (reset)
      m_valid && is_legal(m_instr) |-> ex_imm == exp_imm(m_instr))
    else begin
      $error("[ERROR] ex_imm exp %h got %h", exp_imm($sampled(m_instr)), $sampled(ex_imm));
      fail_count++;
    end

  a_rs: assert property (@(posedge clk) disable iff (reset)
      m_valid |-> ex_rs1_val == m_rs1 && ex_rs2_val == m_rs2)
    else begin
      $error("[ERROR] ex_rs1_val/ex_rs2_val exp %h/%h got %h/%h", $sampled(m_rs1),
        $sampled(m_rs2), $sampled(ex_rs1_val), $sampled(ex_rs2_val));
      fail_count++;
    end

  a_alu: assert property (@(posedge clk) disable iff (reset)
      m_valid && is_legal(m_instr) |-> ex_alu_op == exp_alu(m_instr))
    else begin
      $error("[ERROR] ex_alu_op exp %h got %h", exp_alu($sampled(m_instr)),
        $sampled(ex_alu_op));
      fail_count++;
    end

  a_flags: assert property (@(posedge clk) disable iff (reset)
      {ex_reg_write, ex_mem_write, ex_branch, ex_alu_src_imm, ex_illegal} ==
      exp_flags(m_valid, m_instr))
    else begin
      $error("[ERROR] ex_reg_write/mem_write/branch/alu_src_imm/illegal exp %h got %h",
        exp_flags($sampled(m_valid), $sampled(m_instr)),
        {$sampled(ex_reg_write), $sampled(ex_mem_write), $sampled(ex_branch),
         $sampled(ex_alu_src_imm), $sampled(ex_illegal)});
      fail_count++;
    end

  a_opcode: assert property (@(posedge clk) disable iff (reset)
      m_valid && is_legal(m_instr) |-> ex_opcode == m_instr[6:0])
    else begin
      $error("[ERROR] ex_opcode exp %h got %h", $sampled(m_instr[6:0]), $sampled(ex_opcode));
      fail_count++;
    end

  a_rd: assert property (@(posedge clk) disable iff (reset)
      m_valid |-> ex_rd == (writes_rd(m_instr) ? m_instr[11:7] : 5'd0))
    else begin
      $error("[ERROR] ex_rd exp %h got %h",
        writes_rd($sampled(m_instr)) ? $sampled(m_instr[11:7]) : 5'd0, $sampled(ex_rd));
      fail_count++;
    end

endmodule

bind decode_unit decode_unit_chk u_chk (.*);

// ==== tb/tb_decode_unit.sv ====
`timescale 1ns/100ps

module tb_decode_unit;
  import rv_decode_pkg::*;

  localparam int MAX_CYCLES = 600;  // About twice the test length

  logic      clk;
  logic      reset;
  logic      instr_valid;
  logic      stall;
  data_t     instr;
  logic      wb_en;
  reg_addr_t wb_rd;
  data_t     wb_data;
  logic      ex_valid, ex_reg_write, ex_mem_write, ex_branch, ex_alu_src_imm, ex_illegal;
  opcode_t   ex_opcode;
  alu_op_t   ex_alu_op;
  reg_addr_t ex_rd;
  data_t     ex_rs1_val, ex_rs2_val, ex_imm;
  int        cycles = 0;

  decode_unit DUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Legal majors plus SYSTEM, FENCE and a junk code
  function automatic data_t random_instr();
    logic [6:0] opcs [12] = '{7'h03, 7'h23, 7'h63, 7'h6f, 7'h67, 7'h13,
                              7'h33, 7'h37, 7'h17, 7'h73, 7'h0f, 7'h7f};
    data_t r;
    r = $urandom;
    return {r[31:7], opcs[$urandom % 12]};
  endfunction

  task automatic write_back(input reg_addr_t rd, input data_t data);
    @(posedge clk);
    wb_en   <= 1'b1;
    wb_rd   <= rd;
    wb_data <= data;
  endtask

  // ======================================================================
  // Watchdogs
  // ======================================================================

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles", cycles);
      $display("*** FAILED ***");
      $fatal(1);
    end
  end

  always @(posedge clk) begin
    if (DUT.u_chk.fail_count != 0) begin
      $display("*** FAILED ***");
      $fatal(1);
    end
  end

  // ======================================================================
  // Stimulus
  // ======================================================================

  initial begin
    void'($urandom(1));
    reset       = 1'b1;
    instr_valid = 1'b0;
    stall       = 1'b0;
    instr       = '0;
    wb_en       = 1'b0;
    wb_rd       = '0;
    wb_data     = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    for (int r = 0; r < 32; r++) write_back(reg_addr_t'(r), $urandom);  // x0 write ignored

    // Bypass: read x5 while it is being written
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= 32'h0002_8293;  // addi x5, x5, 0
    wb_en       <= 1'b1;
    wb_rd       <= 5'd5;
    wb_data     <= 32'hcafe_f00d;
    @(posedge clk);
    instr       <= 32'h0000_0033;  // add x0, x0, x0
    wb_en       <= 1'b0;

    for (int n = 0; n < 200; n++) begin
      @(posedge clk);
      instr       <= random_instr();
      instr_valid <= ($urandom % 8) != 0;
      stall       <= ($urandom % 6) == 0;
      wb_en       <= ($urandom % 3) == 0;
      wb_rd       <= reg_addr_t'($urandom);
      wb_data     <= $urandom;
    end
    @(posedge clk);
    instr_valid <= 1'b0;
    stall       <= 1'b0;
    wb_en       <= 1'b0;
    repeat (3) @(posedge clk);

    if (DUT.u_chk.fail_count == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("*** FAILED ***");
      $fatal(1);
    end
  end

endmodule

// ==== files.f ====
+incdir+logic
logic/rv_decode_pkg.sv
logic/decode_ifs.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/id_ex_stage.sv
logic/decode_unit.sv
tb/decode_unit_chk.sv
tb/tb_decode_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator, status follows the testbench result
verilator --binary --assert -Wno-fatal -f files.f --top-module tb_decode_unit -o sim_decode \
  && ./obj_dir/sim_decode | tee /dev/stderr | grep -qF "*** PASSED ***" \
  || exit 1
